// File: run.sh
#!/bin/sh
# build and run the receiver testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal -f tb.f --top-module kv_cmd_rx_tb -o kv_cmd_rx_sim
./obj_dir/kv_cmd_rx_sim +verilator+error+limit+1000 | tee sim.log
if grep -q "Errors found" sim.log; then
   echo "simulation FAILED"
   exit 1
fi
echo "simulation passed"

// File: tb.f
verilog/pkt_types_pkg.sv
verilog/kv_cmd_pkg.sv
verilog/pkt_walker.sv
verilog/cmd_decoder.sv
verilog/update_distributor.sv
verilog/kv_cmd_rx.sv
tb/kv_cmd_rx_properties.sv
tb/kv_cmd_rx_tb.sv

// File: tb/kv_cmd_rx_properties.sv
// Concurrent checks on the receiver outputs.
// Bound into kv_cmd_rx at the end of this file.

module kv_cmd_rx_properties #(
   parameter int NUM_UPDATE_FIFOS = 8
)(
   input logic                        clk,
   input logic                        reset,
   input logic                        in_fifo_vld,
   input logic                        in_fifo_rd_en,
   input logic                        dram_fifo_full,
   input logic                        dram_fifo_write,
   input logic [NUM_UPDATE_FIFOS-1:0] update_wrreq,
   input logic                        flush_ddr,
   input logic                        check_terminate,
   input logic                        compute_system_reset
);

   int failures = 0;

   // at most one update FIFO per written word
   a_wrreq_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(update_wrreq))
      else begin
         $error("update_wrreq has more than one bit set");
         failures++;
      end

   // a word popped against a full DRAM FIFO is never written
   a_no_write_full: assert property (@(posedge clk) disable iff (reset)
         (in_fifo_vld && in_fifo_rd_en && dram_fifo_full) |=> !dram_fifo_write)
      else begin
         $error("dram_fifo_write after a word popped while dram_fifo_full was high");
         failures++;
      end

   // strobes last exactly one cycle
   a_strobe_single: assert property (@(posedge clk) disable iff (reset)
         (flush_ddr || check_terminate || compute_system_reset) |=>
         !((flush_ddr && $past(flush_ddr)) || (check_terminate && $past(check_terminate)) ||
           (compute_system_reset && $past(compute_system_reset))))
      else begin
         $error("strobe high for two cycles in a row");
         failures++;
      end

endmodule

bind kv_cmd_rx kv_cmd_rx_properties #(
   .NUM_UPDATE_FIFOS (NUM_UPDATE_FIFOS)
) props_inst (
   .clk                  (clk),
   .reset                (reset),
   .in_fifo_vld          (in_fifo_vld),
   .in_fifo_rd_en        (in_fifo_rd_en),
   .dram_fifo_full       (dram_fifo_full),
   .dram_fifo_write      (dram_fifo_write),
   .update_wrreq         (update_wrreq),
   .flush_ddr            (flush_ddr),
   .check_terminate      (check_terminate),
   .compute_system_reset (compute_system_reset)
);

// File: tb/kv_cmd_rx_tb.sv
// Drives random packets into the key-value command receiver through a fall-through FIFO model.
// A reference model predicts DRAM writes, update FIFO writes, mode levels and strobes.

module kv_cmd_rx_tb
   import pkt_types_pkg::*, kv_cmd_pkg::*;
();

   localparam int NUM_FIFOS       = 8;
   localparam int RESET_CYCLES    = 5;
   localparam int CYCLES_PER_WORD = 40;

   localparam logic [7:0] CTL_CODES [6] = '{START_LOAD, END_LOAD, START_UPDATE,
                                            END_UPDATE, CHECK_TERMINATE, FLUSH_DATA};
   localparam logic [7:0] PUT_MASKS [3] = '{8'h03, 8'h3F, 8'h5A};

   logic                 clk;
   logic                 reset;
   logic                 in_fifo_vld;
   data_word_t           in_fifo_data;
   ctrl_word_t           in_fifo_ctrl;
   logic                 in_fifo_rd_en;
   logic                 preprocess_vld;
   logic                 is_for_us;
   logic                 is_ip_pkt;
   logic                 rd_preprocess_info;
   logic                 start_load;
   logic                 start_update;
   logic                 flush_ddr;
   logic                 check_terminate;
   logic                 compute_system_reset;
   logic                 dram_fifo_full;
   logic                 dram_fifo_write;
   data_word_t           dram_fifo_writedata;
   logic [NUM_FIFOS-1:0] update_full;
   logic [NUM_FIFOS-1:0] update_wrreq;
   data_word_t           update_data;
   logic [7:0]           proc_bit_mask;

   data_word_t  pkt_data[$];       // packet being sent
   ctrl_word_t  pkt_ctrl[$];
   data_word_t  exp_dram[$];       // expected DRAM writes
   data_word_t  exp_upd_data[$];   // expected update writes
   int          exp_upd_idx[$];
   logic        m_load;
   logic        m_update;
   int          m_ptr;             // model round-robin pointer
   int          n_flush;
   int          n_check;
   int          n_reset;
   int          errors;
   int          test_first_error;
   int          test_pkts;
   int          total_pkts;
   int          total_tests;
   int          cycles;
   int          total_words;

   kv_cmd_rx #(.NUM_UPDATE_FIFOS(NUM_FIFOS)) kv_cmd_rx_inst (.*);

   always #10 clk = ~clk;

   // watchdog limit grows with every generated word
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > RESET_CYCLES + CYCLES_PER_WORD * total_words) begin
         $display("timeout: the DUT stopped consuming packet words after %0d cycles", cycles);
         $display("Errors found");
         $finish;
      end
   end

   // contiguous low ones give their count and any other mask gives 0
   function automatic int start_index(input logic [7:0] mask);
      if (mask != 8'hFF && (mask & (mask + 8'd1)) == 8'd0)
         return $countones(mask);
      return 0;
   endfunction

   task automatic log_error(input string msg);
      $display("** Error at time %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic build_packet(input logic [7:0] code, output int cmd_pos);
      data_word_t w;
      int         n_mod;
      n_mod = $urandom_range(1, 3);
      pkt_data.delete();
      pkt_ctrl.delete();
      for (int i = 0; i < n_mod; i++) begin
         pkt_data.push_back({$urandom, $urandom});
         pkt_ctrl.push_back(8'($urandom_range(1, 255)));   // module header
      end
      for (int i = 0; i < 1 + HDR_WORDS_AFTER_MODULE; i++) begin
         pkt_data.push_back({$urandom, $urandom});
         pkt_ctrl.push_back('0);
      end
      cmd_pos = pkt_data.size();
      w = {$urandom, $urandom};
      w[CMD_LSB +: 8] = code;
      pkt_data.push_back(w);
      pkt_ctrl.push_back('0);
      for (int i = $urandom_range(0, 6); i >= 0; i--) begin   // payload ends on the closing word
         w = ($urandom_range(0, 3) == 0) ? '0 : {$urandom, $urandom};
         pkt_data.push_back(w);
         pkt_ctrl.push_back((i == 0) ? 8'($urandom_range(1, 255)) : 8'h00);
      end
      total_words += pkt_data.size();
   endtask

   // reference model for one consumed word
   task automatic model_word(input int k, input int cmd_pos, input logic accepted,
                             input logic [7:0] code);
      int start;
      int sel;
      start = start_index(proc_bit_mask);
      if (accepted && k > cmd_pos) begin
         if (code == LOAD_DATA) begin
            assert (!dram_fifo_full)
            else log_error("load word popped while the DRAM FIFO was full");
            exp_dram.push_back(pkt_data[k]);
         end else if (code == FPGA_PUT_REQUEST || code == WORKER_PUT_REQUEST) begin
            sel = (m_ptr < start) ? start : m_ptr;
            if (pkt_data[k] != '0 && !update_full[sel]) begin
               exp_upd_idx.push_back(sel);
               exp_upd_data.push_back(pkt_data[k]);
               m_ptr = (sel == NUM_FIFOS - 1) ? start : sel + 1;
            end
         end
      end
   endtask

   task automatic check_outputs();
      data_word_t           want;
      logic [NUM_FIFOS-1:0] onehot;
      if (dram_fifo_write) begin
         assert (exp_dram.size() > 0) else log_error("DRAM write with no word expected");
         if (exp_dram.size() > 0) begin
            want = exp_dram.pop_front();
            assert (dram_fifo_writedata == want)
            else log_error($sformatf("DRAM data %h, expected %h", dram_fifo_writedata, want));
         end
      end
      if (update_wrreq != '0) begin
         assert (exp_upd_idx.size() > 0) else log_error("update write with no word expected");
         if (exp_upd_idx.size() > 0) begin
            onehot = '0;
            onehot[exp_upd_idx[0]] = 1'b1;
            want = exp_upd_data.pop_front();
            assert (update_wrreq == onehot && update_data == want)
            else log_error($sformatf("update wrreq %b data %h, expected %b data %h",
                                     update_wrreq, update_data, onehot, want));
            void'(exp_upd_idx.pop_front());
         end
      end
      if (flush_ddr) n_flush++;
      if (check_terminate) n_check++;
      if (compute_system_reset) n_reset++;
   endtask

   task automatic send_packet(input logic [7:0] code, input logic accepted);
      int         cmd_pos;
      int         k;
      int         n_info;
      logic       showing;
      logic [1:0] verdict;
      build_packet(code, cmd_pos);
      verdict = accepted ? 2'b11 : 2'($urandom_range(0, 2));
      n_flush = 0;
      n_check = 0;
      n_reset = 0;
      n_info  = 0;
      k       = 0;
      showing = 1'b0;
      while (k < pkt_data.size()) begin
         @(posedge clk);
         preprocess_vld <= (n_info == 0);
         {is_for_us, is_ip_pkt} <= verdict;
         if (!showing && $urandom_range(0, 3) != 0)
            showing = 1'b1;                      // FIFO not empty any more
         in_fifo_vld    <= showing;
         in_fifo_data   <= pkt_data[k];
         in_fifo_ctrl   <= pkt_ctrl[k];
         dram_fifo_full <= ($urandom_range(0, 2) == 0);
         update_full    <= NUM_FIFOS'($urandom & $urandom);
         @(negedge clk);
         check_outputs();
         assert (!(in_fifo_vld && in_fifo_rd_en) || n_info > 0)
         else log_error("input word popped before the verdict was read");
         if (rd_preprocess_info) n_info++;
         if (in_fifo_vld && in_fifo_rd_en) begin
            model_word(k, cmd_pos, accepted, code);
            k++;
            showing = 1'b0;
         end
      end
      @(posedge clk);
      in_fifo_vld    <= 1'b0;
      preprocess_vld <= 1'b0;
      repeat (2) begin
         @(negedge clk);
         check_outputs();
         @(posedge clk);
      end
      @(negedge clk);
      if (accepted) begin
         case (code)
            START_LOAD:   m_load   = 1'b1;
            END_LOAD:     m_load   = 1'b0;
            START_UPDATE: m_update = 1'b1;
            END_UPDATE:   m_update = 1'b0;
            default: ;
         endcase
      end
      assert (n_info == 1) else log_error($sformatf("verdict read %0d times", n_info));
      assert (exp_dram.size() == 0 && exp_upd_idx.size() == 0)
      else log_error($sformatf("%0d DRAM and %0d update writes missing",
                               exp_dram.size(), exp_upd_idx.size()));
      assert (start_load == m_load && start_update == m_update)
      else log_error($sformatf("levels load %b update %b, expected %b %b",
                               start_load, start_update, m_load, m_update));
      assert (n_flush == int'(accepted && code == FLUSH_DATA) &&
              n_check == int'(accepted && code == CHECK_TERMINATE) &&
              n_reset == int'(accepted && code == END_LOAD))
      else log_error($sformatf("cmd %0d strobes flush %0d check %0d reset %0d",
                               code, n_flush, n_check, n_reset));
      exp_dram.delete();
      exp_upd_idx.delete();
      exp_upd_data.delete();
      test_pkts++;
   endtask

   task automatic begin_test();
      test_first_error = errors;
      test_pkts = 0;
   endtask

   task automatic end_test(input string name);
      $display("test %-16s %3d packets  %0d errors", name, test_pkts, errors - test_first_error);
      total_pkts += test_pkts;
      total_tests++;
   endtask

   // ========================================================================
   // test sequence
   // ========================================================================

   initial begin
      logic [7:0] code;
      void'($urandom(28109));   // one seed for the whole run
      clk = 1'b0;
      reset = 1'b1;
      in_fifo_vld = 1'b0;
      in_fifo_data = '0;
      in_fifo_ctrl = '0;
      preprocess_vld = 1'b0;
      is_for_us = 1'b0;
      is_ip_pkt = 1'b0;
      dram_fifo_full = 1'b0;
      update_full = '0;
      proc_bit_mask = 8'h00;
      m_load = 1'b0;
      m_update = 1'b0;
      m_ptr = 0;
      errors = 0;
      cycles = 0;
      total_words = 0;
      total_pkts = 0;
      total_tests = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;

      begin_test();
      for (int i = 0; i < 10; i++)
         send_packet(8'($urandom_range(1, 9)), 1'b0);
      send_packet(LOAD_DATA, 1'b1);             // next packet still handled
      end_test("rejected");

      begin_test();
      for (int i = 0; i < 24; i++)
         send_packet(CTL_CODES[$urandom_range(0, 5)], 1'b1);
      end_test("control");

      begin_test();
      for (int i = 0; i < 12; i++)
         send_packet(LOAD_DATA, 1'b1);
      end_test("load");

      foreach (PUT_MASKS[m]) begin
         @(posedge clk);
         proc_bit_mask <= PUT_MASKS[m];
         begin_test();
         for (int i = 0; i < 10; i++)
            send_packet($urandom_range(0, 1) ? FPGA_PUT_REQUEST : WORKER_PUT_REQUEST, 1'b1);
         end_test($sformatf("put mask %h", PUT_MASKS[m]));
      end

      begin_test();
      for (int i = 0; i < 6; i++) begin
         code = ($urandom_range(0, 4) == 0) ? 8'd0 : 8'($urandom_range(10, 255));
         send_packet(code, 1'b1);
         send_packet(LOAD_DATA, 1'b1);
      end
      end_test("unknown cmd");

      $display("summary: %0d tests, %0d packets, %0d check errors, %0d property failures",
               total_tests, total_pkts, errors, kv_cmd_rx_inst.props_inst.failures);
      if (errors == 0 && kv_cmd_rx_inst.props_inst.failures == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

// File: verilog/cmd_decoder.sv
// Turns control commands into registered mode levels and one-cycle strobes.
// Data-carrying commands pass through without effect.

module cmd_decoder
   import kv_cmd_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      cmd_vld,
   input  cmd_code_t cmd,

   output logic      start_load,            // level
   output logic      start_update,          // level
   output logic      flush_ddr,             // pulse
   output logic      check_terminate,       // pulse
   output logic      compute_system_reset   // pulse
);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         start_load           <= 1'b0;
         start_update         <= 1'b0;
         flush_ddr            <= 1'b0;
         check_terminate      <= 1'b0;
         compute_system_reset <= 1'b0;
      end else begin
         flush_ddr            <= 1'b0;   // strobes last one cycle
         check_terminate      <= 1'b0;
         compute_system_reset <= 1'b0;

         if (cmd_vld) begin
            case (cmd)
               START_LOAD: start_load <= 1'b1;
               END_LOAD: begin
                  start_load           <= 1'b0;
                  compute_system_reset <= 1'b1;   // restart compute after a load
               end
               START_UPDATE:    start_update    <= 1'b1;
               END_UPDATE:      start_update    <= 1'b0;
               CHECK_TERMINATE: check_terminate <= 1'b1;
               FLUSH_DATA:      flush_ddr       <= 1'b1;
               default: ;   // load and put commands are handled by the walker
            endcase
         end
      end
   end

endmodule

// File: verilog/kv_cmd_pkg.sv
// Command encodings and walker states of the key-value command receiver.
// Imported by the walker, the decoder and the top level.

package kv_cmd_pkg;

   // ========================================================================
   // command field
   // ========================================================================

   localparam int CMD_WIDTH = 8;
   localparam int CMD_LSB   = 40;    // command byte is bits 47..40 of its word

   // values outside this list are unknown and drop the packet
   typedef enum logic [CMD_WIDTH-1:0] {
      START_LOAD         = 8'd1,
      LOAD_DATA          = 8'd2,
      END_LOAD           = 8'd3,
      FPGA_PUT_REQUEST   = 8'd4,
      WORKER_PUT_REQUEST = 8'd5,
      START_UPDATE       = 8'd6,
      END_UPDATE         = 8'd7,
      CHECK_TERMINATE    = 8'd8,
      FLUSH_DATA         = 8'd9
   } cmd_code_t;

   // ========================================================================
   // packet walker
   // ========================================================================

   // words popped after the first ctrl-zero word, before the command word
   localparam int HDR_WORDS_AFTER_MODULE = 4;

   typedef enum logic [2:0] {
      WAIT_INFO,
      MOVE_MODULE_HDRS,
      SKIP_HDR,
      READ_CMD,
      LOAD_KV,
      ACCUM_KV,
      DROP_PKT
   } walker_state_t;

endpackage

// File: verilog/kv_cmd_rx.sv
// Top level of the key-value command receiver behind the packet input FIFO.
// Connects the packet walker, command decoder and update distributor.

module kv_cmd_rx
   import pkt_types_pkg::*, kv_cmd_pkg::*;
#(
   parameter int NUM_UPDATE_FIFOS = 8
)(
   input  logic                        clk,
   input  logic                        reset,

   // input FIFO
   input  logic                        in_fifo_vld,
   input  data_word_t                  in_fifo_data,
   input  ctrl_word_t                  in_fifo_ctrl,
   output logic                        in_fifo_rd_en,

   // preprocess block
   input  logic                        preprocess_vld,
   input  logic                        is_for_us,
   input  logic                        is_ip_pkt,
   output logic                        rd_preprocess_info,

   // mode levels and strobes
   output logic                        start_load,
   output logic                        start_update,
   output logic                        flush_ddr,
   output logic                        check_terminate,
   output logic                        compute_system_reset,

   // DRAM write FIFO
   input  logic                        dram_fifo_full,
   output logic                        dram_fifo_write,
   output data_word_t                  dram_fifo_writedata,

   // external update FIFOs
   input  logic [NUM_UPDATE_FIFOS-1:0] update_full,
   output logic [NUM_UPDATE_FIFOS-1:0] update_wrreq,
   output data_word_t                  update_data,

   input  logic [7:0]                  proc_bit_mask
);

   logic       cmd_vld;
   cmd_code_t  cmd;
   logic       accum_vld;
   data_word_t accum_data;

   pkt_walker walker_inst (
      .clk                 (clk),
      .reset               (reset),
      .in_fifo_vld         (in_fifo_vld),
      .in_fifo_data        (in_fifo_data),
      .in_fifo_ctrl        (in_fifo_ctrl),
      .in_fifo_rd_en       (in_fifo_rd_en),
      .preprocess_vld      (preprocess_vld),
      .is_for_us           (is_for_us),
      .is_ip_pkt           (is_ip_pkt),
      .rd_preprocess_info  (rd_preprocess_info),
      .cmd_vld             (cmd_vld),
      .cmd                 (cmd),
      .accum_vld           (accum_vld),
      .accum_data          (accum_data),
      .dram_fifo_full      (dram_fifo_full),
      .dram_fifo_write     (dram_fifo_write),
      .dram_fifo_writedata (dram_fifo_writedata)
   );

   cmd_decoder decoder_inst (
      .clk                  (clk),
      .reset                (reset),
      .cmd_vld              (cmd_vld),
      .cmd                  (cmd),
      .start_load           (start_load),
      .start_update         (start_update),
      .flush_ddr            (flush_ddr),
      .check_terminate      (check_terminate),
      .compute_system_reset (compute_system_reset)
   );

   update_distributor #(
      .NUM_UPDATE_FIFOS (NUM_UPDATE_FIFOS)
   ) distributor_inst (
      .clk           (clk),
      .reset         (reset),
      .accum_vld     (accum_vld),
      .accum_data    (accum_data),
      .update_full   (update_full),
      .proc_bit_mask (proc_bit_mask),
      .update_wrreq  (update_wrreq),
      .update_data   (update_data)
   );

endmodule

// File: verilog/pkt_types_pkg.sv
// Word and control types of the packet datapath.
// Imported by every RTL block that carries packet words.

package pkt_types_pkg;

   // ========================================================================
   // widths
   // ========================================================================

   localparam int DATA_WIDTH = 64;   // one packet word
   localparam int CTRL_WIDTH = 8;    // control byte beside each word

   // ========================================================================
   // types
   // ========================================================================

   // one packet word as it comes out of the input FIFO
   typedef logic [DATA_WIDTH-1:0] data_word_t;

   // zero marks a header or payload word
   // nonzero marks a module header or the end of the packet
   typedef logic [CTRL_WIDTH-1:0] ctrl_word_t;

endpackage

// File: verilog/pkt_walker.sv
// Walks each packet of the fall-through input FIFO through verdict, headers and command.
// Load payload goes to the DRAM write port, put payload to the distributor.

module pkt_walker
   import pkt_types_pkg::*, kv_cmd_pkg::*;
(
   input  logic       clk,
   input  logic       reset,

   // input FIFO, fall-through
   input  logic       in_fifo_vld,
   input  data_word_t in_fifo_data,
   input  ctrl_word_t in_fifo_ctrl,
   output logic       in_fifo_rd_en,

   // preprocess verdict, held until read
   input  logic       preprocess_vld,
   input  logic       is_for_us,
   input  logic       is_ip_pkt,
   output logic       rd_preprocess_info,

   // command to the decoder
   output logic       cmd_vld,
   output cmd_code_t  cmd,

   // put-request words to the distributor
   output logic       accum_vld,
   output data_word_t accum_data,

   // DRAM write FIFO
   input  logic       dram_fifo_full,
   output logic       dram_fifo_write,
   output data_word_t dram_fifo_writedata
);

   localparam logic [2:0] HDR_CNT_LAST = 3'(HDR_WORDS_AFTER_MODULE - 1);

   walker_state_t state;
   walker_state_t state_next;
   logic [2:0]    hdr_cnt;          // words popped in SKIP_HDR
   logic          ctrl_prev_zero;   // last consumed word had ctrl zero
   logic          consume;
   logic          eop;

   assign consume = in_fifo_vld & in_fifo_rd_en;
   assign eop     = consume & ctrl_prev_zero & (in_fifo_ctrl != '0);

   assign cmd        = cmd_code_t'(in_fifo_data[CMD_LSB +: CMD_WIDTH]);
   assign cmd_vld    = (state == READ_CMD) & consume;
   assign accum_data = in_fifo_data;
   assign accum_vld  = (state == ACCUM_KV) & consume;

   // ========================================================================
   // next state and FIFO pop
   // ========================================================================

   always_comb begin
      state_next         = state;
      in_fifo_rd_en      = 1'b0;
      rd_preprocess_info = 1'b0;

      case (state)
         WAIT_INFO: begin
            if (preprocess_vld) begin
               rd_preprocess_info = 1'b1;
               state_next = (is_for_us && is_ip_pkt) ? MOVE_MODULE_HDRS : DROP_PKT;
            end
         end

         MOVE_MODULE_HDRS: begin
            in_fifo_rd_en = in_fifo_vld;
            if (consume && in_fifo_ctrl == '0)   // first Ethernet word
               state_next = SKIP_HDR;
         end

         SKIP_HDR: begin
            in_fifo_rd_en = in_fifo_vld;
            if (eop)                             // truncated packet
               state_next = WAIT_INFO;
            else if (consume && hdr_cnt == HDR_CNT_LAST)
               state_next = READ_CMD;
         end

         READ_CMD: begin
            in_fifo_rd_en = in_fifo_vld;
            if (eop) begin
               state_next = WAIT_INFO;
            end else if (consume) begin
               case (cmd)
                  LOAD_DATA:          state_next = LOAD_KV;
                  FPGA_PUT_REQUEST,
                  WORKER_PUT_REQUEST: state_next = ACCUM_KV;
                  default:            state_next = DROP_PKT;
               endcase
            end
         end

         LOAD_KV: begin
            in_fifo_rd_en = in_fifo_vld & ~dram_fifo_full;   // stall while DRAM FIFO is full
            if (eop)
               state_next = WAIT_INFO;
         end

         ACCUM_KV, DROP_PKT: begin
            in_fifo_rd_en = in_fifo_vld;
            if (eop)
               state_next = WAIT_INFO;
         end

         default: state_next = WAIT_INFO;
      endcase
   end

   // ========================================================================
   // registers
   // ========================================================================

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state           <= WAIT_INFO;
         hdr_cnt         <= '0;
         ctrl_prev_zero  <= 1'b0;
         dram_fifo_write <= 1'b0;
      end else begin
         state           <= state_next;
         dram_fifo_write <= (state == LOAD_KV) & consume;
         if (consume)
            ctrl_prev_zero <= (in_fifo_ctrl == '0);
         if (state != SKIP_HDR)
            hdr_cnt <= '0;
         else if (consume)
            hdr_cnt <= hdr_cnt + 3'd1;
      end
   end

   // load word goes out one cycle after it is popped
   always_ff @(posedge clk) begin
      if ((state == LOAD_KV) && consume)
         dram_fifo_writedata <= in_fifo_data;
   end

endmodule

// File: verilog/update_distributor.sv
// Spreads nonzero accumulate words round-robin over the external update FIFOs.
// Words that meet a full FIFO are dropped; there is no back-pressure.

module update_distributor
   import pkt_types_pkg::*;
#(
   parameter int NUM_UPDATE_FIFOS = 8
)(
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        accum_vld,
   input  data_word_t                  accum_data,
   input  logic [NUM_UPDATE_FIFOS-1:0] update_full,
   input  logic [7:0]                  proc_bit_mask,
   output logic [NUM_UPDATE_FIFOS-1:0] update_wrreq,
   output data_word_t                  update_data
);

   localparam int IDX_W = $clog2(NUM_UPDATE_FIFOS);
   localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_UPDATE_FIFOS - 1);

   logic [3:0]       mask_ones;   // ones in a contiguous low mask
   logic [IDX_W-1:0] start_idx;
   logic [IDX_W-1:0] ptr;
   logic [IDX_W-1:0] sel;
   logic             do_write;

   // ========================================================================
   // start index from the processor mask
   // ========================================================================

   always_comb begin
      mask_ones = 4'd0;
      for (int i = 1; i < 8; i++) begin
         if (proc_bit_mask == 8'((1 << i) - 1))
            mask_ones = 4'(i);
      end
   end

   assign start_idx = (mask_ones < NUM_UPDATE_FIFOS) ? mask_ones[IDX_W-1:0] : '0;

   // pointer is kept at or above the start index
   assign sel      = (ptr < start_idx) ? start_idx : ptr;
   assign do_write = accum_vld & (|accum_data) & ~update_full[sel];

   // ========================================================================
   // pointer and write port
   // ========================================================================

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ptr          <= '0;
         update_wrreq <= '0;
      end else begin
         update_wrreq <= '0;
         if (do_write) begin
            update_wrreq[sel] <= 1'b1;
            ptr <= (sel == LAST_IDX) ? start_idx : sel + 1'b1;   // wrap to start
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_write)
         update_data <= accum_data;
   end

endmodule
